// ==== src.f ====
+incdir+include
design/cache_geom_pkg.sv
design/cache_ctrl_pkg.sv
design/intra_bank_arbiter.sv
design/tag_store.sv
design/block_data_array.sv
design/bank_controller.sv
design/unified_cache_bank.sv
bench/tb_unified_cache_bank.sv

// ==== bench/tb_unified_cache_bank.sv ====
`include "cache_bank_defines.svh"

module tb_unified_cache_bank;

    timeunit 1ns;
    timeprecision 1ps;

    import cache_geom_pkg::*;
    import cache_ctrl_pkg::*;

    localparam int  READ_COUNT        = 15;
    localparam int  WORST_READ_CYCLES = 30;
    localparam time TIMEOUT_NS        = (READ_COUNT * WORST_READ_CYCLES + 10) * 100 * 2;

    logic                                   clk;
    logic                                   rst_n;
    addr_t [`NUM_INPUT_PORT - 1 : 0]        request_address;
    logic [`NUM_INPUT_PORT - 1 : 0]         request_valid;
    logic [`NUM_INPUT_PORT - 1 : 0]         request_critical;
    logic [`NUM_INPUT_PORT - 1 : 0]         request_ack;
    addr_t                                  miss_request_address;
    logic                                   miss_request_valid;
    logic                                   miss_request_ack;
    block_t                                 fetched_block;
    logic                                   fetched_valid;
    logic                                   fetch_ack;
    addr_t                                  return_address;
    port_id_t                               return_port;
    block_t                                 return_block;
    logic                                   return_valid;
    logic                                   return_ack;

    // model of the bank contents and of the next level.
    logic [`NUM_WAY - 1 : 0] model_valid [`NUM_SET];
    tag_t                    model_tag   [`NUM_SET][`NUM_WAY];
    int                      model_ptr   [`NUM_SET];
    integer                  seed;
    int                      miss_count;
    int                      miss_hold;
    addr_t                   expected_miss_address;

    unified_cache_bank dut
    (
        .*
    );

    always #50 clk = ~clk;

    task check_value(input string name, input logic [31:0] actual, input logic [31:0] expected);
        if (actual !== expected)
        begin
            $display("Fail at %0d ns: %s is %h, expected %h", $time, name, actual, expected);
            $display("TEST FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    // the index is address bits 3:2 and the tag is everything above.
    function automatic logic model_hit(input addr_t addr);
        for (int w = 0; w < `NUM_WAY; w++)
        begin
            if (model_valid[addr[3:2]][w] && model_tag[addr[3:2]][w] == addr[31:4])
            begin
                return 1'b1;
            end
        end
        return 1'b0;
    endfunction

    task automatic model_fill(input addr_t addr);
        model_valid[addr[3:2]][model_ptr[addr[3:2]]] = 1'b1;
        model_tag[addr[3:2]][model_ptr[addr[3:2]]]   = addr[31:4];
        model_ptr[addr[3:2]]                         = (model_ptr[addr[3:2]] + 1) % `NUM_WAY;
    endtask

    // the next level acks the miss after miss_hold cycles and answers after 0 to 3 cycles.
    initial
    begin
        forever
        begin
            @(negedge clk);
            if (miss_request_valid)
            begin
                repeat (miss_hold)
                begin
                    check_value("miss_request_address", miss_request_address,
                                expected_miss_address);
                    check_value("request_ack", request_ack, 0);
                    @(negedge clk);
                    check_value("miss_request_valid", miss_request_valid, 1);
                end
                check_value("miss_request_address", miss_request_address, expected_miss_address);
                miss_request_ack = 1'b1;
                @(negedge clk);
                miss_request_ack = 1'b0;
                miss_count++;
                repeat ($unsigned($random(seed)) % 4) @(negedge clk);
                fetched_block = expected_miss_address ^ 32'h5a5a_a5a5;
                fetched_valid = 1'b1;
                #10;
                while (!fetch_ack)
                begin
                    @(negedge clk);
                    #10;
                end
                @(negedge clk);
                fetched_valid = 1'b0;
            end
        end
    end

    // called on the falling edge where the request was driven.
    task automatic wait_accept(input int port);
        #10;
        while (request_ack == '0)
        begin
            @(negedge clk);
            #10;
        end
        check_value("request_ack", request_ack, 2'b01 << port);
        @(negedge clk);
        request_valid[port]    = 1'b0;
        request_critical[port] = 1'b0;
    endtask

    // starts on the falling edge after the accept edge.
    task automatic complete_read(input int port, input addr_t addr, input int hold);
        logic   expect_hit;
        int     misses_before;
        int     edges;
        block_t expected_block;
        expect_hit            = model_hit(addr);
        misses_before         = miss_count;
        expected_miss_address = {addr[31:2], 2'b00};
        expected_block        = expected_miss_address ^ 32'h5a5a_a5a5;
        edges                 = 0;
        while (!return_valid)
        begin
            check_value("request_ack", request_ack, 0);
            @(negedge clk);
            edges++;
        end
        for (int i = 0; i <= hold; i++)
        begin
            if (i > 0)
            begin
                check_value("request_ack", request_ack, 0);
                @(negedge clk);
            end
            check_value("return_valid", return_valid, 1);
            check_value("return_address", return_address, addr);
            check_value("return_port", return_port, port);
            check_value("return_block", return_block, expected_block);
        end
        return_ack = 1'b1;
        @(negedge clk);
        return_ack = 1'b0;
        if (expect_hit)
        begin
            check_value("hit return latency", edges, 2);
            check_value("miss request count", miss_count, misses_before);
        end
        else
        begin
            check_value("miss request count", miss_count, misses_before + 1);
            model_fill(addr);
        end
    endtask

    task automatic read_check(input int port, input addr_t addr, input int hold);
        @(negedge clk);
        request_address[port] = addr;
        request_valid[port]   = 1'b1;
        wait_accept(port);
        complete_read(port, addr, hold);
    endtask

    task automatic arbitration_test(input addr_t addr0, input logic crit0, input addr_t addr1,
                                    input logic crit1, input int winner, input int hold);
        @(negedge clk);
        request_address[0]  = addr0;
        request_address[1]  = addr1;
        request_critical[0] = crit0;
        request_critical[1] = crit1;
        request_valid       = 2'b11;
        wait_accept(winner);
        complete_read(winner, winner ? addr1 : addr0, hold);
        wait_accept(1 - winner);
        complete_read(1 - winner, winner ? addr0 : addr1, 0);
    endtask

    task automatic reset_test();
        check_value("request_ack", request_ack, 0);
        check_value("miss_request_valid", miss_request_valid, 0);
        check_value("fetch_ack", fetch_ack, 0);
        check_value("return_valid", return_valid, 0);
    endtask

    task automatic eviction_test();
        // five tags of set 1 are read in turn and the fifth replaces the first.
        for (int t = 1; t <= 5; t++)
        begin
            read_check(t % 2, addr_t'(t << 16) | 32'h4, 0);
        end
        read_check(0, 32'h0001_0004, 0);
        read_check(1, 32'h0004_0004, 0);
    endtask

    initial
    begin
        seed                  = 32'h1010_410f;
        clk                   = 1'b0;
        rst_n                 = 1'b0;
        request_address       = '0;
        request_valid         = '0;
        request_critical      = '0;
        miss_request_ack      = 1'b0;
        fetched_block         = '0;
        fetched_valid         = 1'b0;
        return_ack            = 1'b0;
        miss_count            = 0;
        miss_hold             = 0;
        expected_miss_address = '0;
        for (int s = 0; s < `NUM_SET; s++)
        begin
            model_valid[s] = '0;
            model_ptr[s]   = 0;
        end
        repeat (3) @(negedge clk);
        rst_n = 1'b1;
        reset_test();
        read_check(0, 32'h0000_0103, 0);
        read_check(1, 32'h0000_0101, 0);
        arbitration_test(32'h0000_0208, 1'b0, 32'h0000_030c, 1'b1, 1, 0);
        arbitration_test(32'h0000_0408, 1'b0, 32'h0000_050c, 1'b0, 0, 0);
        eviction_test();
        // port 0 keeps waiting while the critical read on port 1 is held back.
        miss_hold = 3;
        arbitration_test(32'h0000_070c, 1'b0, 32'h0000_0608, 1'b1, 1, 4);
        miss_hold = 0;
        $display("TEST OK");
        $finish;
    end

    initial
    begin
        #(TIMEOUT_NS);
        $display("timeout: the bank did not finish the directed tests in time");
        $display("TEST FAILED");
        $fatal(1, "watchdog expired");
    end

endmodule

// ==== design/unified_cache_bank.sv ====
`include "cache_bank_defines.svh"

module unified_cache_bank
(
    input  logic                                            clk,
    input  logic                                            rst_n,
    input  cache_geom_pkg::addr_t [`NUM_INPUT_PORT - 1 : 0] request_address,
    input  logic [`NUM_INPUT_PORT - 1 : 0]                  request_valid,
    input  logic [`NUM_INPUT_PORT - 1 : 0]                  request_critical,
    output logic [`NUM_INPUT_PORT - 1 : 0]                  request_ack,
    output cache_geom_pkg::addr_t                           miss_request_address,
    output logic                                            miss_request_valid,
    input  logic                                            miss_request_ack,
    input  cache_geom_pkg::block_t                          fetched_block,
    input  logic                                            fetched_valid,
    output logic                                            fetch_ack,
    output cache_geom_pkg::addr_t                           return_address,
    output cache_ctrl_pkg::port_id_t                        return_port,
    output cache_geom_pkg::block_t                          return_block,
    output logic                                            return_valid,
    input  logic                                            return_ack
);

    import cache_geom_pkg::*;
    import cache_ctrl_pkg::*;

    logic                        arb_accept;
    logic                        grant_valid;
    port_id_t                    grant_port;
    addr_t                       grant_address;
    logic                        lookup_en;
    index_t                      lookup_index;
    tag_t                        lookup_tag;
    logic                        hit;
    way_t                        hit_way;
    way_t                        victim_way;
    logic                        fill_en;
    way_t                        fill_way;
    tag_t                        fill_tag;
    logic                        data_read_en;
    logic                        data_write_en;
    way_t                        data_way;
    block_t [`NUM_WAY - 1 : 0]   read_block;

    // criticality only steers the arbiter choice, the controller does not need it.
    intra_bank_arbiter u_arbiter
    (
        .grant_critical (),
        .*
    );

    // fills always target the set of the request in flight.
    tag_store u_tag_store
    (
        .fill_index (lookup_index),
        .*
    );

    block_data_array u_data_array
    (
        .clk         (clk),
        .read_en     (data_read_en),
        .write_en    (data_write_en),
        .index       (lookup_index),
        .way         (data_way),
        .write_block (fetched_block),
        .read_block  (read_block)
    );

    bank_controller u_controller
    (
        .*
    );

endmodule

// ==== design/bank_controller.sv ====
`include "cache_bank_defines.svh"

module bank_controller
(
    input  logic                                      clk,
    input  logic                                      rst_n,
    output logic                                      arb_accept,
    input  logic                                      grant_valid,
    input  cache_ctrl_pkg::port_id_t                  grant_port,
    input  cache_geom_pkg::addr_t                     grant_address,
    output logic                                      lookup_en,
    output cache_geom_pkg::index_t                    lookup_index,
    output cache_geom_pkg::tag_t                      lookup_tag,
    input  logic                                      hit,
    input  cache_geom_pkg::way_t                      hit_way,
    input  cache_geom_pkg::way_t                      victim_way,
    output logic                                      fill_en,
    output cache_geom_pkg::way_t                      fill_way,
    output cache_geom_pkg::tag_t                      fill_tag,
    output logic                                      data_read_en,
    output logic                                      data_write_en,
    output cache_geom_pkg::way_t                      data_way,
    input  cache_geom_pkg::block_t [`NUM_WAY - 1 : 0] read_block,
    output cache_geom_pkg::addr_t                     miss_request_address,
    output logic                                      miss_request_valid,
    input  logic                                      miss_request_ack,
    input  cache_geom_pkg::block_t                    fetched_block,
    input  logic                                      fetched_valid,
    output logic                                      fetch_ack,
    output cache_geom_pkg::addr_t                     return_address,
    output cache_ctrl_pkg::port_id_t                  return_port,
    output cache_geom_pkg::block_t                    return_block,
    output logic                                      return_valid,
    input  logic                                      return_ack
);

    import cache_geom_pkg::*;
    import cache_ctrl_pkg::*;

    localparam int OFFSET_WIDTH = $clog2(`BLOCK_WIDTH / 8);
    localparam int INDEX_WIDTH  = $bits(index_t);

    ctrl_state_t state;
    logic        phase;
    addr_t       req_address;
    port_id_t    req_port;

    // phase splits lookup into issue and compare, and fill_wait into fill and settle.
    assign arb_accept    = (state == idle);
    assign lookup_en     = (state == lookup) && !phase;
    assign data_read_en  = lookup_en;
    assign fetch_ack     = (state == fill_wait) && !phase && fetched_valid;
    assign fill_en       = fetch_ack;
    assign data_write_en = fetch_ack;

    // the victim was registered at lookup and stays put until the next lookup.
    assign fill_way = victim_way;
    assign data_way = victim_way;

    assign lookup_index = req_address[OFFSET_WIDTH +: INDEX_WIDTH];
    assign lookup_tag   = req_address[`ADDR_WIDTH - 1 : OFFSET_WIDTH + INDEX_WIDTH];
    assign fill_tag     = lookup_tag;

    assign miss_request_address = {req_address[`ADDR_WIDTH - 1 : OFFSET_WIDTH],
                                   {OFFSET_WIDTH{1'b0}}};
    assign miss_request_valid   = (state == miss_issue);

    assign return_address = req_address;
    assign return_port    = req_port;
    assign return_valid   = (state == respond);

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            state <= idle;
            phase <= 1'b0;
        end
        else
        begin
            case (state)
                idle:
                begin
                    if (grant_valid)
                    begin
                        state <= lookup;
                    end
                end
                lookup:
                begin
                    phase <= ~phase;
                    if (phase)
                    begin
                        state <= hit ? respond : miss_issue;
                    end
                end
                miss_issue:
                begin
                    if (miss_request_ack)
                    begin
                        state <= fill_wait;
                    end
                end
                fill_wait:
                begin
                    if (phase)
                    begin
                        phase <= 1'b0;
                        state <= respond;
                    end
                    else if (fetched_valid)
                    begin
                        phase <= 1'b1;
                    end
                end
                respond:
                begin
                    if (return_ack)
                    begin
                        state <= idle;
                    end
                end
                default:
                begin
                    state <= idle;
                    phase <= 1'b0;
                end
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (arb_accept && grant_valid)
        begin
            req_address <= grant_address;
            req_port    <= grant_port;
        end
        if (state == lookup && phase && hit)
        begin
            return_block <= read_block[hit_way];
        end
        else if (fetch_ack)
        begin
            return_block <= fetched_block;
        end
    end

endmodule

// ==== design/block_data_array.sv ====
`include "cache_bank_defines.svh"

module block_data_array
(
    input  logic                                      clk,
    input  logic                                      read_en,
    input  logic                                      write_en,
    input  cache_geom_pkg::index_t                    index,
    input  cache_geom_pkg::way_t                      way,
    input  cache_geom_pkg::block_t                    write_block,
    output cache_geom_pkg::block_t [`NUM_WAY - 1 : 0] read_block
);

    import cache_geom_pkg::*;

    block_t mem [`NUM_SET][`NUM_WAY];

    // a read returns every way of the set, a write touches a single way.
    always_ff @(posedge clk)
    begin
        if (write_en)
        begin
            mem[index][way] <= write_block;
        end
        else if (read_en)
        begin
            for (int w = 0; w < `NUM_WAY; w++)
            begin
                read_block[w] <= mem[index][w];
            end
        end
    end

endmodule

// ==== design/tag_store.sv ====
`include "cache_bank_defines.svh"

module tag_store
(
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   lookup_en,
    input  cache_geom_pkg::index_t lookup_index,
    input  cache_geom_pkg::tag_t   lookup_tag,
    output logic                   hit,
    output cache_geom_pkg::way_t   hit_way,
    output cache_geom_pkg::way_t   victim_way,
    input  logic                   fill_en,
    input  cache_geom_pkg::index_t fill_index,
    input  cache_geom_pkg::way_t   fill_way,
    input  cache_geom_pkg::tag_t   fill_tag
);

    import cache_geom_pkg::*;

    logic [`NUM_WAY - 1 : 0] valid_bits [`NUM_SET];
    tag_t                    tags       [`NUM_SET][`NUM_WAY];
    way_t                    rr_ptr     [`NUM_SET];
    logic [`NUM_WAY - 1 : 0] way_match;
    way_t                    match_way;

    always_comb
    begin
        for (int w = 0; w < `NUM_WAY; w++)
        begin
            way_match[w] = valid_bits[lookup_index][w] && (tags[lookup_index][w] == lookup_tag);
        end
    end

    // a block is filled only after it missed, so at most one way can match.
    always_comb
    begin
        match_way = '0;
        for (int w = 0; w < `NUM_WAY; w++)
        begin
            if (way_match[w])
            begin
                match_way = way_t'(w);
            end
        end
    end

    // the pointer of a set moves on with every fill, wrapping after the last way.
    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            for (int s = 0; s < `NUM_SET; s++)
            begin
                valid_bits[s] <= '0;
                rr_ptr[s]     <= '0;
            end
        end
        else if (fill_en)
        begin
            valid_bits[fill_index][fill_way] <= 1'b1;
            rr_ptr[fill_index]               <= rr_ptr[fill_index] + 1'b1;
        end
    end

    always_ff @(posedge clk)
    begin
        if (fill_en)
        begin
            tags[fill_index][fill_way] <= fill_tag;
        end
    end

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            hit        <= 1'b0;
            hit_way    <= '0;
            victim_way <= '0;
        end
        else if (lookup_en)
        begin
            hit        <= |way_match;
            hit_way    <= match_way;
            victim_way <= rr_ptr[lookup_index];
        end
    end

endmodule

// ==== design/intra_bank_arbiter.sv ====
`include "cache_bank_defines.svh"

module intra_bank_arbiter
(
    input  logic                                            clk,
    input  logic                                            rst_n,
    input  cache_geom_pkg::addr_t [`NUM_INPUT_PORT - 1 : 0] request_address,
    input  logic [`NUM_INPUT_PORT - 1 : 0]                  request_valid,
    input  logic [`NUM_INPUT_PORT - 1 : 0]                  request_critical,
    output logic [`NUM_INPUT_PORT - 1 : 0]                  request_ack,
    input  logic                                            arb_accept,
    output logic                                            grant_valid,
    output cache_ctrl_pkg::port_id_t                        grant_port,
    output cache_geom_pkg::addr_t                           grant_address,
    output logic                                            grant_critical
);

    import cache_ctrl_pkg::*;

    logic [`NUM_INPUT_PORT - 1 : 0] critical_valid;
    logic [`NUM_INPUT_PORT - 1 : 0] candidates;
    port_id_t                       chosen;

    // critical requests win as a group, the port number only breaks ties.
    assign critical_valid = request_valid & request_critical;
    assign candidates     = (|critical_valid) ? critical_valid : request_valid;

    // scanning downward leaves the lowest candidate port in chosen.
    always_comb
    begin
        chosen = '0;
        for (int i = `NUM_INPUT_PORT - 1; i >= 0; i--)
        begin
            if (candidates[i])
            begin
                chosen = port_id_t'(i);
            end
        end
    end

    assign grant_valid    = |request_valid;
    assign grant_port     = chosen;
    assign grant_address  = request_address[chosen];
    assign grant_critical = request_critical[chosen];

    always_comb
    begin
        request_ack = '0;
        if (arb_accept && grant_valid)
        begin
            request_ack[chosen] = 1'b1;
        end
    end

endmodule

// ==== design/cache_ctrl_pkg.sv ====
`include "cache_bank_defines.svh"

package cache_ctrl_pkg;

    typedef enum logic [2:0]
    {
        idle,
        lookup,
        miss_issue,
        fill_wait,
        respond
    } ctrl_state_t;

    typedef logic [$clog2(`NUM_INPUT_PORT) - 1 : 0] port_id_t;

endpackage

// ==== design/cache_geom_pkg.sv ====
`include "cache_bank_defines.svh"

package cache_geom_pkg;

    // byte address as seen on every port of the bank.
    typedef logic [`ADDR_WIDTH - 1 : 0] addr_t;

    // the set index sits just above the byte offset of the block.
    typedef logic [$clog2(`NUM_SET) - 1 : 0] index_t;

    // everything above the index is kept as the tag.
    typedef logic [`ADDR_WIDTH - $clog2(`NUM_SET) - $clog2(`BLOCK_WIDTH / 8) - 1 : 0] tag_t;

    typedef logic [$clog2(`NUM_WAY) - 1 : 0] way_t;

    typedef logic [`BLOCK_WIDTH - 1 : 0] block_t;

endpackage

// ==== include/cache_bank_defines.svh ====
`ifndef CACHE_BANK_DEFINES_SVH
`define CACHE_BANK_DEFINES_SVH

// number of requesters that share this bank.
`define NUM_INPUT_PORT 2

// geometry of the bank: 4 sets of 4 ways each.
`define NUM_SET 4
`define NUM_WAY 4

// one block holds 4 bytes.
`define BLOCK_WIDTH 32

// byte address width of a request.
`define ADDR_WIDTH 32

`endif
